/* ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Width of every data value and register.
`define XLEN 32

// Architectural registers, x0 included.
`define REG_NUM 32

// Reorder buffer entries. Entry k is addressed by nick k+1.
`define ROB_DEPTH 8

// Free entries held back when raising stall.
// They cover the instruction that is still in decode and the one being sent.
`define STALL_MARGIN 2

`endif

/* oooPkg.sv */
`include "ooo_defines.svh"

package oooPkg;

    typedef logic [`XLEN-1:0]                  dataT;
    typedef logic [$clog2(`REG_NUM)-1:0]       regNameT;
    typedef logic [$clog2(`ROB_DEPTH+1)-1:0]   nickT;
    typedef logic [31:0]                       addrT;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_LUI,
        OP_NOP
    } opT;

    typedef struct packed {
        logic    valid;
        opT      op;
        regNameT rd;
        regNameT rs1;
        regNameT rs2;
        dataT    imm;
        addrT    pc;
    } decodedInstT;

    // A nick of zero means the operand data field already holds the value.
    typedef struct packed {
        logic    valid;
        opT      op;
        regNameT rd;
        nickT    nick;
        nickT    rs1Nick;
        nickT    rs2Nick;
        dataT    rs1Data;
        dataT    rs2Data;
        dataT    imm;
        addrT    pc;
    } dispatchT;

    typedef struct packed {
        logic valid;
        nickT nick;
        dataT data;
    } resultT;

    typedef struct packed {
        logic    valid;
        regNameT rd;
        nickT    nick;
        dataT    data;
    } commitT;

endpackage

/* instDecode.sv */
`timescale 1ns/1ns

module instDecode
    import oooPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        instValid,
    input  logic [31:0] instWord,
    input  addrT        instPc,
    output decodedInstT decoded
);

    localparam logic [6:0] opcodeReg = 7'b0110011;
    localparam logic [6:0] opcodeImm = 7'b0010011;
    localparam logic [6:0] opcodeLui = 7'b0110111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    opT         nextOp;
    dataT       nextImm;
    logic       readsRs1;
    logic       readsRs2;

    assign opcode = instWord[6:0];
    assign funct3 = instWord[14:12];
    assign funct7 = instWord[31:25];

    always_comb begin
        nextOp  = OP_NOP;
        nextImm = '0;
        case (opcode)
            opcodeReg: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  nextOp = OP_ADD;
                        3'b100:  nextOp = OP_XOR;
                        3'b110:  nextOp = OP_OR;
                        3'b111:  nextOp = OP_AND;
                        default: nextOp = OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    nextOp = OP_SUB;
                end
            end
            opcodeImm: begin
                if (funct3 == 3'b000) begin
                    nextOp  = OP_ADDI;
                    nextImm = {{20{instWord[31]}}, instWord[31:20]};
                end
            end
            opcodeLui: begin
                nextOp  = OP_LUI;
                nextImm = {instWord[31:12], 12'b0};
            end
            default: ;
        endcase
    end

    // Unused source fields read x0 so that they never pick up a nick.
    assign readsRs1 = nextOp != OP_NOP && nextOp != OP_LUI;
    assign readsRs2 = readsRs1 && nextOp != OP_ADDI;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded.valid <= instValid;
        end
        decoded.op  <= nextOp;
        decoded.rd  <= (nextOp == OP_NOP) ? regNameT'(0) : instWord[11:7];
        decoded.rs1 <= readsRs1 ? instWord[19:15] : regNameT'(0);
        decoded.rs2 <= readsRs2 ? instWord[24:20] : regNameT'(0);
        decoded.imm <= nextImm;
        decoded.pc  <= instPc;
    end

    assert property (@(posedge clk) disable iff (rst) decoded.valid |-> $past(instValid))
        else $error("decoded entry appeared without an instruction");

endmodule

/* regFile.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module regFile
    import oooPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  decodedInstT decoded,
    input  nickT        allocNick,
    output logic        allocate,
    output dispatchT    dispatch,
    input  commitT      commit
);

    dataT regValue [`REG_NUM];
    nickT regNick  [`REG_NUM];

    nickT rs1Nick;
    nickT rs2Nick;
    dataT rs1Data;
    dataT rs2Data;
    logic renameRd;

    function automatic logic commitHit(regNameT name);
        return commit.valid && commit.rd == name && name != '0;
    endfunction

    // A commit in the same cycle is seen by the read, as if it had landed first.
    function automatic nickT readNick(regNameT name);
        nickT n;
        n = regNick[name];
        if (commitHit(name) && n == commit.nick) begin
            n = '0;
        end
        return n;
    endfunction

    function automatic dataT readData(regNameT name);
        return commitHit(name) ? commit.data : regValue[name];
    endfunction

    always_comb begin
        rs1Nick = readNick(decoded.rs1);
        rs2Nick = readNick(decoded.rs2);
        rs1Data = readData(decoded.rs1);
        rs2Data = readData(decoded.rs2);
    end

    assign renameRd = decoded.rd != '0 && decoded.op != OP_NOP;
    assign allocate = decoded.valid;

    always_ff @(posedge clk) begin
        dispatch.op      <= decoded.op;
        dispatch.rd      <= decoded.rd;
        dispatch.nick    <= allocNick;
        dispatch.rs1Nick <= rs1Nick;
        dispatch.rs2Nick <= rs2Nick;
        dispatch.rs1Data <= rs1Data;
        dispatch.rs2Data <= rs2Data;
        dispatch.imm     <= decoded.imm;
        dispatch.pc      <= decoded.pc;

        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regValue[i] <= '0;
                regNick[i]  <= '0;
            end
            dispatch.valid <= 1'b0;
        end else begin
            // The value always lands. Only the newest renamer may clear the nick.
            if (commit.valid && commit.rd != '0) begin
                regValue[commit.rd] <= commit.data;
                if (regNick[commit.rd] == commit.nick) begin
                    regNick[commit.rd] <= '0;
                end
            end

            if (flush) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    regNick[i] <= '0;
                end
                dispatch.valid <= 1'b0;
            end else begin
                dispatch.valid <= decoded.valid;
                if (decoded.valid && renameRd) begin
                    regNick[decoded.rd] <= allocNick;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) regNick[0] == '0)
        else $error("x0 was given a nick");

endmodule

/* executeUnit.sv */
`timescale 1ns/1ns

module executeUnit
    import oooPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  dispatchT dispatch,
    output nickT     lookupNick1,
    output nickT     lookupNick2,
    input  dataT     lookupData1,
    input  dataT     lookupData2,
    output resultT   result
);

    dataT opA;
    dataT opB;
    dataT aluOut;

    assign lookupNick1 = dispatch.rs1Nick;
    assign lookupNick2 = dispatch.rs2Nick;

    // Every older instruction has already executed, so a tagged operand
    // is always available from the reorder buffer at this point.
    assign opA = (dispatch.rs1Nick != '0) ? lookupData1 : dispatch.rs1Data;
    assign opB = (dispatch.rs2Nick != '0) ? lookupData2 : dispatch.rs2Data;

    always_comb begin
        case (dispatch.op)
            OP_ADD:  aluOut = opA + opB;
            OP_SUB:  aluOut = opA - opB;
            OP_AND:  aluOut = opA & opB;
            OP_OR:   aluOut = opA | opB;
            OP_XOR:  aluOut = opA ^ opB;
            OP_ADDI: aluOut = opA + dispatch.imm;
            OP_LUI:  aluOut = dispatch.imm;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= dispatch.valid;
        end
        result.nick <= dispatch.nick;
        result.data <= aluOut;
    end

endmodule

/* reorderBuffer.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module reorderBuffer
    import oooPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    allocate,
    input  regNameT dispatchRd,
    output nickT    allocNick,
    input  nickT    lookupNick1,
    input  nickT    lookupNick2,
    output dataT    lookupData1,
    output dataT    lookupData2,
    input  resultT  result,
    output commitT  commit,
    output logic    stall
);

    localparam int ptrW = $clog2(`ROB_DEPTH);

    typedef logic [ptrW-1:0] ptrT;
    typedef logic [ptrW:0]   countT;

    ptrT     head;
    ptrT     tail;
    countT   count;
    logic    [`ROB_DEPTH-1:0] entryDone;
    regNameT entryRd   [`ROB_DEPTH];
    dataT    entryData [`ROB_DEPTH];

    nickT headNick;
    ptrT  resultIdx;
    ptrT  resultOffset;
    logic headBypass;
    logic headReady;

    function automatic ptrT nickToIdx(nickT n);
        return ptrT'(n - nickT'(1));
    endfunction

    // A result registered this cycle is not in the array yet.
    function automatic dataT lookup(nickT n);
        if (result.valid && result.nick == n) begin
            return result.data;
        end
        return entryData[nickToIdx(n)];
    endfunction

    assign allocNick   = nickT'(tail) + nickT'(1);
    assign headNick    = nickT'(head) + nickT'(1);
    assign lookupData1 = lookup(lookupNick1);
    assign lookupData2 = lookup(lookupNick2);

    assign resultIdx    = nickToIdx(result.nick);
    assign resultOffset = resultIdx - head;

    assign headBypass = result.valid && result.nick == headNick;
    assign headReady  = count != '0 && (entryDone[head] || headBypass);

    assign stall = (count + countT'(allocate)) >= countT'(`ROB_DEPTH - `STALL_MARGIN);

    always_ff @(posedge clk) begin
        if (allocate) begin
            entryRd[tail] <= dispatchRd;
        end
        if (result.valid) begin
            entryData[resultIdx] <= result.data;
        end
    end

    always_ff @(posedge clk) begin
        commit.rd   <= entryRd[head];
        commit.nick <= headNick;
        commit.data <= entryDone[head] ? entryData[head] : result.data;

        if (rst || flush) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            entryDone    <= '0;
            commit.valid <= 1'b0;
        end else begin
            if (allocate) begin
                entryDone[tail] <= 1'b0;
                tail            <= tail + ptrT'(1);
            end
            if (result.valid) begin
                entryDone[resultIdx] <= 1'b1;
            end
            commit.valid <= headReady;
            if (headReady) begin
                head <= head + ptrT'(1);
            end
            count <= count + countT'(allocate) - countT'(headReady);
        end
    end

    assert property (@(posedge clk) disable iff (rst || flush)
        allocate |-> count < countT'(`ROB_DEPTH))
        else $error("allocation into a full reorder buffer");

    assert property (@(posedge clk) disable iff (rst || flush)
        result.valid |-> countT'(resultOffset) < count)
        else $error("result for a free reorder buffer entry");

endmodule

/* oooCore.sv */
`timescale 1ns/1ns

module oooCore
    import oooPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        instValid,
    input  logic [31:0] instWord,
    input  addrT        instPc,
    output logic        stall,
    output logic        commitValid,
    output regNameT     commitRd,
    output dataT        commitData
);

    decodedInstT decoded;
    dispatchT    dispatch;
    resultT      result;
    commitT      commit;
    nickT        allocNick;
    nickT        lookupNick1;
    nickT        lookupNick2;
    dataT        lookupData1;
    dataT        lookupData2;
    logic        allocate;

    instDecode uDecode (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .instValid (instValid),
        .instWord  (instWord),
        .instPc    (instPc),
        .decoded   (decoded)
    );

    regFile uRegFile (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .decoded   (decoded),
        .allocNick (allocNick),
        .allocate  (allocate),
        .dispatch  (dispatch),
        .commit    (commit)
    );

    executeUnit uExecute (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .dispatch    (dispatch),
        .lookupNick1 (lookupNick1),
        .lookupNick2 (lookupNick2),
        .lookupData1 (lookupData1),
        .lookupData2 (lookupData2),
        .result      (result)
    );

    // The ROB records rd at the same edge that the register file renames it.
    reorderBuffer uRob (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .allocate    (allocate),
        .dispatchRd  (decoded.rd),
        .allocNick   (allocNick),
        .lookupNick1 (lookupNick1),
        .lookupNick2 (lookupNick2),
        .lookupData1 (lookupData1),
        .lookupData2 (lookupData2),
        .result      (result),
        .commit      (commit),
        .stall       (stall)
    );

    assign commitValid = commit.valid;
    assign commitRd    = commit.rd;
    assign commitData  = commit.data;

endmodule

/* tb_oooCore.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module tb_oooCore
    import oooPkg::*;
();

    localparam int chainCount = 200;
    localparam int immCount   = 100;
    localparam int zeroCount  = 80;
    localparam int burstCount = 150;
    localparam int flushRound = 4;
    localparam int flushCount = 60;
    localparam int totalInsts = chainCount + immCount + zeroCount + burstCount
                              + flushRound * 12 + flushCount + 2;
    localparam int timeoutCycles = totalInsts * 8 + 500;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        instValid;
    logic [31:0] instWord;
    addrT        instPc;
    logic        stall;
    logic        commitValid;
    regNameT     commitRd;
    dataT        commitData;

    // Speculative registers follow every sent instruction, retired ones follow commits.
    dataT    specReg [`REG_NUM];
    dataT    doneReg [`REG_NUM];
    regNameT expRd   [$];
    dataT    expData [$];
    opT      opTable [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI};
    addrT    pc;
    int      errorCount;
    int      errorsBefore;
    int      checkCount;
    int      commitCount;
    int      stallCycles;
    int      startCommits;
    int      latency;

    oooCore dut (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .instValid   (instValid),
        .instWord    (instWord),
        .instPc      (instPc),
        .stall       (stall),
        .commitValid (commitValid),
        .commitRd    (commitRd),
        .commitData  (commitData)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Advances to the next falling edge and retires whatever the core committed.
    task automatic stepClock();
        regNameT rd;
        dataT    data;
        @(negedge clk);
        if (commitValid) begin
            commitCount++;
            if (expRd.size() == 0) begin
                errorCount++;
                $display("Commit to x%0d arrived with no instruction pending", commitRd);
            end else begin
                rd   = expRd.pop_front();
                data = expData.pop_front();
                checkValue("commitRd", 32'(commitRd), 32'(rd));
                checkValue("commitData", commitData, data);
                if (rd != 0) begin
                    doneReg[rd] = data;
                end
            end
        end
        // Every instruction still queued is either in decode or holds a reorder buffer entry.
        checkValue("stall", 32'(stall),
                   32'(expRd.size() >= `ROB_DEPTH - `STALL_MARGIN));
    endtask

    function automatic logic [31:0] encodeInst(opT op, regNameT rd, regNameT rs1,
                                               regNameT rs2, logic [19:0] immBits);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] word;
        f7 = (op == OP_SUB) ? 7'b0100000 : 7'b0000000;
        case (op)
            OP_XOR:  f3 = 3'b100;
            OP_OR:   f3 = 3'b110;
            OP_AND:  f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        case (op)
            OP_ADDI: word = {immBits[11:0], rs1, 3'b000, rd, 7'b0010011};
            OP_LUI:  word = {immBits, rd, 7'b0110111};
            default: word = {f7, rs2, rs1, f3, rd, 7'b0110011};
        endcase
        return word;
    endfunction

    task automatic sendOp(input opT op, input regNameT rd, input regNameT rs1,
                          input regNameT rs2, input logic [19:0] immBits);
        dataT a;
        dataT b;
        dataT imm;
        dataT res;
        while (stall) begin
            stallCycles++;
            stepClock();
        end
        a   = specReg[rs1];
        b   = specReg[rs2];
        imm = {{20{immBits[11]}}, immBits[11:0]};
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm;
            default: res = {immBits, 12'b0};
        endcase
        if (rd != 0) begin
            specReg[rd] = res;
        end
        expRd.push_back(rd);
        expData.push_back(res);
        instValid = 1'b1;
        instWord  = encodeInst(op, rd, rs1, rs2, immBits);
        instPc    = pc;
        pc        = pc + 4;
        stepClock();
        instValid = 1'b0;
    endtask

    task automatic sendRandom(input bit immOnly, input int regLo, input int regHi);
        opT op;
        op = immOnly ? opTable[$urandom_range(6, 5)] : opTable[$urandom_range(6, 0)];
        sendOp(op, regNameT'($urandom_range(regHi, regLo)),
               regNameT'($urandom_range(regHi, regLo)),
               regNameT'($urandom_range(regHi, regLo)), 20'($urandom()));
    endtask

    // Everything not yet retired is dropped, so the model falls back to retired state.
    task automatic pulseFlush();
        flush     = 1'b1;
        instValid = 1'b0;
        expRd.delete();
        expData.delete();
        for (int i = 0; i < `REG_NUM; i++) begin
            specReg[i] = doneReg[i];
        end
        stepClock();
        flush = 1'b0;
    endtask

    task automatic finishTest(input int num, input string name);
        while (expRd.size() != 0) begin
            stepClock();
        end
        repeat (3) stepClock();
        $display("Test %0d %s: %0d errors", num, name, errorCount - errorsBefore);
        errorsBefore = errorCount;
    endtask

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Watchdog stopped the run after %0d cycles", timeoutCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h5a1f));
        clk          = 1'b0;
        rst          = 1'b1;
        flush        = 1'b0;
        instValid    = 1'b0;
        instWord     = '0;
        instPc       = '0;
        pc           = '0;
        errorCount   = 0;
        errorsBefore = 0;
        checkCount   = 0;
        commitCount  = 0;
        stallCycles  = 0;
        for (int i = 0; i < `REG_NUM; i++) begin
            specReg[i] = '0;
            doneReg[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < chainCount; i++) begin
            sendRandom(1'b0, 1, 4);
        end
        finishTest(1, "dependent chains");

        for (int i = 0; i < immCount; i++) begin
            sendRandom(1'b1, 0, 31);
        end
        finishTest(2, "immediates");

        for (int i = 0; i < zeroCount; i++) begin
            sendRandom(1'b0, 0, 3);
        end
        sendOp(OP_OR, 5'd5, 5'd0, 5'd0, 20'h0);
        finishTest(3, "x0 handling");

        startCommits = commitCount;
        for (int i = 0; i < burstCount; i++) begin
            sendRandom(1'b0, 1, 6);
        end
        finishTest(4, "back-pressure");
        checkValue("commit count", 32'(commitCount - startCommits), 32'(burstCount));
        $display("Stall held the source for %0d cycles", stallCycles);

        for (int r = 0; r < flushRound; r++) begin
            repeat ($urandom_range(12, 3)) sendRandom(1'b0, 1, 8);
            pulseFlush();
        end
        for (int i = 0; i < flushCount; i++) begin
            sendRandom(1'b0, 1, 8);
        end
        finishTest(5, "flush");

        // The queue is empty here, so the first commit belongs to this instruction.
        startCommits = commitCount;
        sendOp(OP_ADDI, 5'd9, 5'd1, 5'd0, 20'h00abc);
        latency = 1;
        while (commitCount == startCommits) begin
            stepClock();
            latency++;
        end
        checkValue("commit latency", 32'(latency), 32'd4);
        finishTest(6, "single-instruction latency");

        $display("Tests: 6, checks: %0d, commits: %0d, errors: %0d",
                 checkCount, commitCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
oooPkg.sv
instDecode.sv
regFile.sv
executeUnit.sv
reorderBuffer.sv
oooCore.sv
tb_oooCore.sv

/* Makefile */
TOP = tb_oooCore

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
